// ==== tomasulo_rs.f ====
+incdir+source
source/rs_pkg.sv
source/rs_dispatch.sv
source/rs_entry.sv
source/rs_issue.sv
source/rs_top.sv
test/rs_tb.sv

// ==== Bender.yml ====
package:
  name: tomasulo_rs

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/rs_pkg.sv
      - source/rs_dispatch.sv
      - source/rs_entry.sv
      - source/rs_issue.sv
      - source/rs_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - test/rs_tb.sv

// ==== test/rs_tb.sv ====
`include "rs_params.svh"

module rs_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int N = `RS_NUM_ENTRIES;
  localparam rs_pkg::fu_kind_t [N-1:0] FU_LIST = `RS_FU_LIST;
  localparam int RANDOM_CYCLES = 3000;
  localparam int WAIT_LIMIT = 40;   // Cycles before a wait gives up
  localparam int SEED = 31928;

  typedef struct {
    logic             busy;
    logic             ready1;
    logic             ready2;
    rs_pkg::op_code_t op;
    rs_pkg::rob_idx_t rob;
    rs_pkg::pr_tag_t  dest;
    rs_pkg::pr_tag_t  src1;
    rs_pkg::pr_tag_t  src2;
  } model_entry_t;

  logic                                  clock;
  logic                                  reset;
  logic                                  dispatch_en;
  rs_pkg::fu_kind_t                      dispatch_kind;
  rs_pkg::op_code_t                      dispatch_op;
  rs_pkg::rob_idx_t                      dispatch_rob_idx;
  rs_pkg::pr_tag_t                       dispatch_dest_tag;
  rs_pkg::pr_tag_t                       dispatch_src1_tag;
  logic                                  dispatch_src1_ready;
  rs_pkg::pr_tag_t                       dispatch_src2_tag;
  logic                                  dispatch_src2_ready;
  logic                                  cdb_valid;
  rs_pkg::pr_tag_t                       cdb_tag;
  logic                                  rollback_en;
  rs_pkg::rob_idx_t                      rollback_rob_idx;
  rs_pkg::rob_idx_t                      rollback_distance;
  logic             [N-1:0]              fu_free;
  logic                                  dispatch_stall;
  logic             [N-1:0]              issue_valid;
  rs_pkg::op_code_t [N-1:0]              issue_op;
  rs_pkg::rob_idx_t [N-1:0]              issue_rob_idx;
  rs_pkg::pr_tag_t  [N-1:0]              issue_dest_tag;
  rs_pkg::pr_tag_t  [N-1:0]              issue_src1_tag;
  rs_pkg::pr_tag_t  [N-1:0]              issue_src2_tag;

  model_entry_t model [N];    // Station contents after the coming edge
  model_entry_t packet [N];   // Expected issue payload per unit
  logic         exp_valid [N];

  rs_top uut (.*);

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  function automatic string mismatch_line(input string name, input int unit,
                                          input logic [31:0] expected,
                                          input logic [31:0] actual);
    return $sformatf("FAILED %s[%0d]: expected 0x%0h, got 0x%0h", name, unit, expected, actual);
  endfunction

  task automatic check_stall(input logic expected);
    if (dispatch_stall !== expected) begin
      fail_run($sformatf("FAILED dispatch_stall: expected 0x%0h, got 0x%0h",
                         expected, dispatch_stall));
    end
  endtask

  task automatic check_issue(input rs_pkg::entry_idx_t unit, input logic valid,
                             input rs_pkg::op_code_t op, input rs_pkg::rob_idx_t rob,
                             input rs_pkg::pr_tag_t dest, input rs_pkg::pr_tag_t src1,
                             input rs_pkg::pr_tag_t src2);
    if (issue_valid[unit] !== valid) begin
      fail_run(mismatch_line("issue_valid", unit, valid, issue_valid[unit]));
    end else if (valid && issue_op[unit] !== op) begin
      fail_run(mismatch_line("issue_op", unit, op, issue_op[unit]));
    end else if (valid && issue_rob_idx[unit] !== rob) begin
      fail_run(mismatch_line("issue_rob_idx", unit, rob, issue_rob_idx[unit]));
    end else if (valid && issue_dest_tag[unit] !== dest) begin
      fail_run(mismatch_line("issue_dest_tag", unit, dest, issue_dest_tag[unit]));
    end else if (valid && issue_src1_tag[unit] !== src1) begin
      fail_run(mismatch_line("issue_src1_tag", unit, src1, issue_src1_tag[unit]));
    end else if (valid && issue_src2_tag[unit] !== src2) begin
      fail_run(mismatch_line("issue_src2_tag", unit, src2, issue_src2_tag[unit]));
    end
  endtask

  // Falling edge: compare last edge's packets, then drop one-cycle strobes
  task automatic start_cycle();
    @(negedge clock);
    for (int i = 0; i < N; i++) begin
      check_issue(rs_pkg::entry_idx_t'(i), exp_valid[i], packet[i].op, packet[i].rob,
                  packet[i].dest, packet[i].src1, packet[i].src2);
    end
    dispatch_en = 1'b0;
    cdb_valid   = 1'b0;
    rollback_en = 1'b0;
  endtask

  // Predict stall and grants from the driven inputs, then advance the model
  task automatic predict_cycle();
    logic             hit;
    logic             ready1_now;
    logic             ready2_now;
    logic             squash;
    logic             grant;
    logic             found;
    int               target;
    rs_pkg::rob_idx_t offset;
    #1;
    hit    = cdb_valid && (cdb_tag != rs_pkg::pr_tag_t'(`RS_ZERO_PR));
    found  = 1'b0;
    target = 0;
    for (int i = 0; i < N; i++) begin
      if (!found && !model[i].busy && FU_LIST[i] == dispatch_kind) begin
        found  = 1'b1;
        target = i;
      end
    end
    check_stall(dispatch_en && !found);
    for (int i = 0; i < N; i++) begin
      ready1_now = model[i].ready1 || (hit && cdb_tag == model[i].src1);
      ready2_now = model[i].ready2 || (hit && cdb_tag == model[i].src2);
      offset     = model[i].rob - rollback_rob_idx;   // Modulo the ROB depth
      squash     = rollback_en && model[i].busy && (offset <= rollback_distance);
      grant      = model[i].busy && ready1_now && ready2_now && !squash && fu_free[i];
      exp_valid[i] = grant;
      if (grant) begin
        packet[i] = model[i];
      end
      model[i].ready1 = ready1_now;
      model[i].ready2 = ready2_now;
      if (grant || squash) begin
        model[i].busy = 1'b0;
      end
    end
    if (dispatch_en && found) begin
      model[target].busy   = 1'b1;
      model[target].ready1 = dispatch_src1_ready || (hit && cdb_tag == dispatch_src1_tag);
      model[target].ready2 = dispatch_src2_ready || (hit && cdb_tag == dispatch_src2_tag);
      model[target].op     = dispatch_op;
      model[target].rob    = dispatch_rob_idx;
      model[target].dest   = dispatch_dest_tag;
      model[target].src1   = dispatch_src1_tag;
      model[target].src2   = dispatch_src2_tag;
    end
  endtask

  task automatic drive_dispatch(input rs_pkg::fu_kind_t kind, input rs_pkg::op_code_t op,
                                input rs_pkg::rob_idx_t rob, input rs_pkg::pr_tag_t src1,
                                input logic ready1, input rs_pkg::pr_tag_t src2,
                                input logic ready2);
    dispatch_en         = 1'b1;
    dispatch_kind       = kind;
    dispatch_op         = op;
    dispatch_rob_idx    = rob;
    dispatch_dest_tag   = rs_pkg::pr_tag_t'($urandom);
    dispatch_src1_tag   = src1;
    dispatch_src1_ready = ready1;
    dispatch_src2_tag   = src2;
    dispatch_src2_ready = ready2;
  endtask

  task automatic dispatch_cycle(input rs_pkg::fu_kind_t kind, input rs_pkg::op_code_t op,
                                input rs_pkg::rob_idx_t rob, input rs_pkg::pr_tag_t src1,
                                input logic ready1, input rs_pkg::pr_tag_t src2,
                                input logic ready2);
    start_cycle();
    drive_dispatch(kind, op, rob, src1, ready1, src2, ready2);
    predict_cycle();
  endtask

  task automatic broadcast_cycle(input rs_pkg::pr_tag_t tag);
    start_cycle();
    cdb_valid = 1'b1;
    cdb_tag   = tag;
    predict_cycle();
  endtask

  task automatic rollback_cycle(input rs_pkg::rob_idx_t index, input rs_pkg::rob_idx_t distance);
    start_cycle();
    rollback_en       = 1'b1;
    rollback_rob_idx  = index;
    rollback_distance = distance;
    predict_cycle();
  endtask

  task automatic units_cycle(input logic [N-1:0] free_mask);
    start_cycle();
    fu_free = free_mask;
    predict_cycle();
  endtask

  task automatic idle_cycles(input int count);
    repeat (count) begin
      start_cycle();
      predict_cycle();
    end
  endtask

  task automatic wait_for_issue(input int unit);
    int count;
    count = 0;
    start_cycle();
    while (issue_valid[unit] !== 1'b1) begin
      predict_cycle();
      count++;
      if (count > WAIT_LIMIT) begin
        fail_run($sformatf("timeout: unit %0d never issued a packet", unit));
      end else begin
        start_cycle();
      end
    end
    predict_cycle();
  endtask

  // Small tag pool so that broadcasts hit, zero a quarter of the time
  function automatic rs_pkg::pr_tag_t pool_tag();
    if ($urandom_range(3) == 0) begin
      return rs_pkg::pr_tag_t'(`RS_ZERO_PR);
    end
    return rs_pkg::pr_tag_t'($urandom_range(7, 1));
  endfunction

  initial begin
    rs_pkg::pr_tag_t src1;
    rs_pkg::pr_tag_t src2;
    void'($urandom(SEED));
    reset               = 1'b1;
    dispatch_en         = 1'b0;
    dispatch_kind       = '0;
    dispatch_op         = '0;
    dispatch_rob_idx    = '0;
    dispatch_dest_tag   = '0;
    dispatch_src1_tag   = '0;
    dispatch_src1_ready = 1'b0;
    dispatch_src2_tag   = '0;
    dispatch_src2_ready = 1'b0;
    cdb_valid           = 1'b0;
    cdb_tag             = '0;
    rollback_en         = 1'b0;
    rollback_rob_idx    = '0;
    rollback_distance   = '0;
    fu_free             = '0;   // Units busy for the allocation burst
    for (int i = 0; i < N; i++) begin
      model[i]     = '{default: '0};
      packet[i]    = '{default: '0};
      exp_valid[i] = 1'b0;
    end
    repeat (5) @(negedge clock);
    reset = 1'b0;

    // Three ALU entries, so the fourth and fifth ALU dispatch stall
    for (int k = 0; k < 5; k++) begin
      dispatch_cycle(`FU_ALU, rs_pkg::op_code_t'(k + 1), rs_pkg::rob_idx_t'(k), '0, 1'b1,
                     '0, 1'b1);
      check_stall(k >= 3);
    end
    idle_cycles(4);                                          // Ready entries held back
    dispatch_cycle(`FU_ALU, 6'd7, 5'd7, '0, 1'b1, '0, 1'b1);
    check_stall(1'b1);
    dispatch_cycle(`FU_MULT, 6'd8, 5'd8, '0, 1'b1, '0, 1'b1);
    check_stall(1'b0);
    units_cycle('1);
    wait_for_issue(5);

    // Wakeup by a matching broadcast only, tag zero wakes nothing
    dispatch_cycle(`FU_ALU, 6'd20, 5'd1, 6'd9, 1'b0, '0, 1'b1);
    idle_cycles(3);
    broadcast_cycle('0);
    idle_cycles(2);
    broadcast_cycle(6'd9);
    wait_for_issue(0);
    start_cycle();
    drive_dispatch(`FU_ALU, 6'd21, 5'd2, 6'd12, 1'b0, 6'd12, 1'b0);
    cdb_valid = 1'b1;                                        // Same-cycle wakeup
    cdb_tag   = 6'd12;
    predict_cycle();
    wait_for_issue(0);
    dispatch_cycle(`FU_MEM, 6'd22, 5'd10, '0, 1'b0, '0, 1'b1);
    broadcast_cycle('0);
    idle_cycles(3);

    // Rollback window of 8 to 12 catches only the MEM entry
    dispatch_cycle(`FU_ALU, 6'd23, 5'd20, 6'd13, 1'b0, '0, 1'b1);
    dispatch_cycle(`FU_BRANCH, 6'd24, 5'd2, 6'd14, 1'b0, '0, 1'b1);
    rollback_cycle(5'd8, 5'd4);
    broadcast_cycle(6'd13);
    wait_for_issue(0);
    dispatch_cycle(`FU_MEM, 6'd25, 5'd11, '0, 1'b1, '0, 1'b1);
    check_stall(1'b0);
    wait_for_issue(3);
    rollback_cycle(5'd30, 5'd5);                             // Wraps past zero
    dispatch_cycle(`FU_BRANCH, 6'd26, 5'd3, '0, 1'b1, '0, 1'b1);
    check_stall(1'b0);
    wait_for_issue(4);

    // Rollback in the grant cycle wins over issue
    units_cycle(6'b111011);
    dispatch_cycle(`FU_MULT, 6'd27, 5'd16, '0, 1'b1, '0, 1'b1);
    idle_cycles(2);
    start_cycle();
    fu_free           = '1;
    rollback_en       = 1'b1;
    rollback_rob_idx  = 5'd16;
    rollback_distance = 5'd0;
    predict_cycle();
    idle_cycles(2);
    dispatch_cycle(`FU_MULT, 6'd28, 5'd17, '0, 1'b1, '0, 1'b1);
    check_stall(1'b0);
    wait_for_issue(2);

    for (int c = 0; c < RANDOM_CYCLES; c++) begin
      start_cycle();
      if ($urandom_range(99) < 60) begin
        src1 = pool_tag();
        src2 = pool_tag();
        drive_dispatch(rs_pkg::fu_kind_t'($urandom_range(3)), rs_pkg::op_code_t'($urandom),
                       rs_pkg::rob_idx_t'($urandom), src1,
                       (src1 == '0) || ($urandom_range(1) == 1), src2,
                       (src2 == '0) || ($urandom_range(1) == 1));
      end
      if ($urandom_range(1) == 1) begin
        cdb_valid = 1'b1;
        cdb_tag   = pool_tag();
      end
      if ($urandom_range(99) < 3) begin
        rollback_en       = 1'b1;
        rollback_rob_idx  = rs_pkg::rob_idx_t'($urandom);
        rollback_distance = rs_pkg::rob_idx_t'($urandom_range(7));
      end
      for (int i = 0; i < N; i++) begin
        fu_free[i] = $urandom_range(2) != 0;
      end
      predict_cycle();
    end

    $display("TEST PASSED");
    $finish;
  end

endmodule

// ==== source/rs_top.sv ====
`include "rs_params.svh"

module rs_top (
  input  logic                                          clock,
  input  logic                                          reset,
  input  logic                                          dispatch_en,
  input  rs_pkg::fu_kind_t                              dispatch_kind,
  input  rs_pkg::op_code_t                              dispatch_op,
  input  rs_pkg::rob_idx_t                              dispatch_rob_idx,
  input  rs_pkg::pr_tag_t                               dispatch_dest_tag,
  input  rs_pkg::pr_tag_t                               dispatch_src1_tag,
  input  logic                                          dispatch_src1_ready,
  input  rs_pkg::pr_tag_t                               dispatch_src2_tag,
  input  logic                                          dispatch_src2_ready,
  input  logic                                          cdb_valid,
  input  rs_pkg::pr_tag_t                               cdb_tag,
  input  logic                                          rollback_en,
  input  rs_pkg::rob_idx_t                              rollback_rob_idx,
  input  rs_pkg::rob_idx_t                              rollback_distance,
  input  logic             [`RS_NUM_ENTRIES-1:0]        fu_free,
  output logic                                          dispatch_stall,
  output logic             [`RS_NUM_ENTRIES-1:0]        issue_valid,
  output rs_pkg::op_code_t [`RS_NUM_ENTRIES-1:0]        issue_op,
  output rs_pkg::rob_idx_t [`RS_NUM_ENTRIES-1:0]        issue_rob_idx,
  output rs_pkg::pr_tag_t  [`RS_NUM_ENTRIES-1:0]        issue_dest_tag,
  output rs_pkg::pr_tag_t  [`RS_NUM_ENTRIES-1:0]        issue_src1_tag,
  output rs_pkg::pr_tag_t  [`RS_NUM_ENTRIES-1:0]        issue_src2_tag
);

  logic             [`RS_NUM_ENTRIES-1:0] busy;
  logic             [`RS_NUM_ENTRIES-1:0] entry_write;     // One-hot from the allocator
  logic             [`RS_NUM_ENTRIES-1:0] issue_request;
  logic             [`RS_NUM_ENTRIES-1:0] entry_grant;
  rs_pkg::op_code_t [`RS_NUM_ENTRIES-1:0] entry_op;        // Stored fields per entry
  rs_pkg::rob_idx_t [`RS_NUM_ENTRIES-1:0] entry_rob_idx;
  rs_pkg::pr_tag_t  [`RS_NUM_ENTRIES-1:0] entry_dest_tag;
  rs_pkg::pr_tag_t  [`RS_NUM_ENTRIES-1:0] entry_src1_tag;
  rs_pkg::pr_tag_t  [`RS_NUM_ENTRIES-1:0] entry_src2_tag;

  rs_dispatch u_dispatch (
    .dispatch_en    (dispatch_en),
    .dispatch_kind  (dispatch_kind),
    .busy           (busy),
    .entry_write    (entry_write),
    .dispatch_stall (dispatch_stall)
  );

  // Payload fans out to every entry, only the strobed one captures
  for (genvar i = 0; i < `RS_NUM_ENTRIES; i++) begin : g_entry
    rs_entry u_entry (
      .clock               (clock),
      .reset               (reset),
      .write               (entry_write[i]),
      .dispatch_op         (dispatch_op),
      .dispatch_rob_idx    (dispatch_rob_idx),
      .dispatch_dest_tag   (dispatch_dest_tag),
      .dispatch_src1_tag   (dispatch_src1_tag),
      .dispatch_src1_ready (dispatch_src1_ready),
      .dispatch_src2_tag   (dispatch_src2_tag),
      .dispatch_src2_ready (dispatch_src2_ready),
      .cdb_valid           (cdb_valid),
      .cdb_tag             (cdb_tag),
      .rollback_en         (rollback_en),
      .rollback_rob_idx    (rollback_rob_idx),
      .rollback_distance   (rollback_distance),
      .grant               (entry_grant[i]),
      .busy                (busy[i]),
      .issue_request       (issue_request[i]),
      .op                  (entry_op[i]),
      .rob_idx             (entry_rob_idx[i]),
      .dest_tag            (entry_dest_tag[i]),
      .src1_tag            (entry_src1_tag[i]),
      .src2_tag            (entry_src2_tag[i])
    );
  end

  rs_issue u_issue (
    .clock          (clock),
    .reset          (reset),
    .issue_request  (issue_request),
    .fu_free        (fu_free),
    .entry_op       (entry_op),
    .entry_rob_idx  (entry_rob_idx),
    .entry_dest_tag (entry_dest_tag),
    .entry_src1_tag (entry_src1_tag),
    .entry_src2_tag (entry_src2_tag),
    .entry_grant    (entry_grant),
    .issue_valid    (issue_valid),
    .issue_op       (issue_op),
    .issue_rob_idx  (issue_rob_idx),
    .issue_dest_tag (issue_dest_tag),
    .issue_src1_tag (issue_src1_tag),
    .issue_src2_tag (issue_src2_tag)
  );

endmodule

// ==== source/rs_issue.sv ====
`include "rs_params.svh"

module rs_issue (
  input  logic                                          clock,
  input  logic                                          reset,
  input  logic             [`RS_NUM_ENTRIES-1:0]        issue_request,
  input  logic             [`RS_NUM_ENTRIES-1:0]        fu_free,
  input  rs_pkg::op_code_t [`RS_NUM_ENTRIES-1:0]        entry_op,
  input  rs_pkg::rob_idx_t [`RS_NUM_ENTRIES-1:0]        entry_rob_idx,
  input  rs_pkg::pr_tag_t  [`RS_NUM_ENTRIES-1:0]        entry_dest_tag,
  input  rs_pkg::pr_tag_t  [`RS_NUM_ENTRIES-1:0]        entry_src1_tag,
  input  rs_pkg::pr_tag_t  [`RS_NUM_ENTRIES-1:0]        entry_src2_tag,
  output logic             [`RS_NUM_ENTRIES-1:0]        entry_grant,
  output logic             [`RS_NUM_ENTRIES-1:0]        issue_valid,
  output rs_pkg::op_code_t [`RS_NUM_ENTRIES-1:0]        issue_op,
  output rs_pkg::rob_idx_t [`RS_NUM_ENTRIES-1:0]        issue_rob_idx,
  output rs_pkg::pr_tag_t  [`RS_NUM_ENTRIES-1:0]        issue_dest_tag,
  output rs_pkg::pr_tag_t  [`RS_NUM_ENTRIES-1:0]        issue_src1_tag,
  output rs_pkg::pr_tag_t  [`RS_NUM_ENTRIES-1:0]        issue_src2_tag
);

  // Each entry owns its unit, so no arbitration between entries
  assign entry_grant = issue_request & fu_free;

  always_ff @(posedge clock) begin
    if (reset) begin
      issue_valid <= '0;
    end else begin
      issue_valid <= entry_grant;   // One cycle pulse per grant
    end
  end

  // Packet payload holds between issues
  always_ff @(posedge clock) begin
    for (int i = 0; i < `RS_NUM_ENTRIES; i++) begin
      if (entry_grant[i]) begin
        issue_op[i]       <= entry_op[i];
        issue_rob_idx[i]  <= entry_rob_idx[i];
        issue_dest_tag[i] <= entry_dest_tag[i];
        issue_src1_tag[i] <= entry_src1_tag[i];
        issue_src2_tag[i] <= entry_src2_tag[i];
      end
    end
  end

  // A granted entry goes idle, so its unit never issues two cycles running
  for (genvar i = 0; i < `RS_NUM_ENTRIES; i++) begin : g_unit_check
    back_to_back_needs_grants: assert property (
      @(posedge clock) disable iff (reset)
      issue_valid[i] |=> !issue_valid[i]
    ) else $error("rs_issue: unit %0d issued twice without two grants", i);
  end

endmodule

// ==== source/rs_entry.sv ====
`include "rs_params.svh"

module rs_entry (
  input  logic                clock,
  input  logic                reset,
  input  logic                write,
  input  rs_pkg::op_code_t    dispatch_op,
  input  rs_pkg::rob_idx_t    dispatch_rob_idx,
  input  rs_pkg::pr_tag_t     dispatch_dest_tag,
  input  rs_pkg::pr_tag_t     dispatch_src1_tag,
  input  logic                dispatch_src1_ready,
  input  rs_pkg::pr_tag_t     dispatch_src2_tag,
  input  logic                dispatch_src2_ready,
  input  logic                cdb_valid,
  input  rs_pkg::pr_tag_t     cdb_tag,
  input  logic                rollback_en,
  input  rs_pkg::rob_idx_t    rollback_rob_idx,
  input  rs_pkg::rob_idx_t    rollback_distance,
  input  logic                grant,
  output logic                busy,
  output logic                issue_request,
  output rs_pkg::op_code_t    op,
  output rs_pkg::rob_idx_t    rob_idx,
  output rs_pkg::pr_tag_t     dest_tag,
  output rs_pkg::pr_tag_t     src1_tag,
  output rs_pkg::pr_tag_t     src2_tag
);

  rs_pkg::entry_state_t state;
  rs_pkg::entry_state_t state_next;

  logic             src1_ready;       // Stored ready bits
  logic             src2_ready;
  logic             cdb_hit;          // Broadcast that can wake something
  logic             src1_wake;        // Stored tag matches the broadcast
  logic             src2_wake;
  logic             new_src1_wake;    // Incoming tag matches the broadcast
  logic             new_src2_wake;
  logic             src1_ready_now;
  logic             src2_ready_now;
  rs_pkg::rob_idx_t rollback_offset;  // Distance from the rollback point
  logic             squash;

  // Tag zero is never produced, so a broadcast of it wakes nothing
  assign cdb_hit = cdb_valid && (cdb_tag != rs_pkg::pr_tag_t'(`RS_ZERO_PR));

  assign src1_wake     = cdb_hit && (cdb_tag == src1_tag);
  assign src2_wake     = cdb_hit && (cdb_tag == src2_tag);
  assign new_src1_wake = cdb_hit && (cdb_tag == dispatch_src1_tag);
  assign new_src2_wake = cdb_hit && (cdb_tag == dispatch_src2_tag);

  assign src1_ready_now = src1_ready || src1_wake;
  assign src2_ready_now = src2_ready || src2_wake;

  // Wraps modulo the ROB depth
  assign rollback_offset = rob_idx - rollback_rob_idx;
  assign squash = rollback_en && (state == rs_pkg::ENTRY_WAITING) &&
                  (rollback_offset <= rollback_distance);

  assign busy = state == rs_pkg::ENTRY_WAITING;

  assign issue_request = (state == rs_pkg::ENTRY_WAITING) && src1_ready_now &&
                         src2_ready_now && !squash;

  always_comb begin
    state_next = state;
    case (state)
      rs_pkg::ENTRY_IDLE: begin
        if (write) begin
          state_next = rs_pkg::ENTRY_WAITING;
        end
      end
      rs_pkg::ENTRY_WAITING: begin
        if (grant || squash) begin
          state_next = rs_pkg::ENTRY_IDLE;   // Issued or rolled back
        end
      end
      default: state_next = rs_pkg::ENTRY_IDLE;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state      <= rs_pkg::ENTRY_IDLE;
      src1_ready <= 1'b0;
      src2_ready <= 1'b0;
    end else begin
      state <= state_next;
      if (write) begin
        src1_ready <= dispatch_src1_ready || new_src1_wake;   // Wakeup in the write cycle
        src2_ready <= dispatch_src2_ready || new_src2_wake;
      end else begin
        src1_ready <= src1_ready_now;
        src2_ready <= src2_ready_now;
      end
    end
  end

  // Instruction fields, held until the next write
  always_ff @(posedge clock) begin
    if (write) begin
      op       <= dispatch_op;
      rob_idx  <= dispatch_rob_idx;
      dest_tag <= dispatch_dest_tag;
      src1_tag <= dispatch_src1_tag;
      src2_tag <= dispatch_src2_tag;
    end
  end

  // The allocator must only pick idle entries
  write_only_when_idle: assert property (
    @(posedge clock) disable iff (reset)
    write |-> state == rs_pkg::ENTRY_IDLE
  ) else $error("rs_entry: write while waiting");

  // Issue stage grants only what was requested
  grant_needs_request: assert property (
    @(posedge clock) disable iff (reset)
    grant |-> issue_request
  ) else $error("rs_entry: grant without request");

endmodule

// ==== source/rs_dispatch.sv ====
`include "rs_params.svh"

module rs_dispatch (
  input  logic                         dispatch_en,
  input  rs_pkg::fu_kind_t             dispatch_kind,
  input  logic [`RS_NUM_ENTRIES-1:0]   busy,
  output logic [`RS_NUM_ENTRIES-1:0]   entry_write,
  output logic                         dispatch_stall
);

  localparam rs_pkg::fu_kind_t [`RS_NUM_ENTRIES-1:0] FU_LIST = `RS_FU_LIST;

  logic [`RS_NUM_ENTRIES-1:0] kind_match;   // Entry unit matches the instruction
  logic [`RS_NUM_ENTRIES-1:0] candidate;    // Idle and matching
  logic                       found;

  always_comb begin
    for (int i = 0; i < `RS_NUM_ENTRIES; i++) begin
      kind_match[i] = FU_LIST[i] == dispatch_kind;
      candidate[i]  = kind_match[i] && !busy[i];
    end
  end

  // Priority scan, the lowest entry number wins
  always_comb begin
    entry_write = '0;
    found       = 1'b0;
    for (int i = 0; i < `RS_NUM_ENTRIES; i++) begin
      if (!found && candidate[i]) begin
        entry_write[i] = dispatch_en;   // Strobe only on a real dispatch
        found          = 1'b1;
      end
    end
  end

  // Stall only when asked to dispatch with every entry of the kind in use
  assign dispatch_stall = dispatch_en && !found;

  // Busy comes from the entries, so this checks the loop across modules
  always_comb begin
    assert #0 ($onehot0(entry_write) && ((entry_write & busy) == '0))
      else $error("rs_dispatch: entry_write %b against busy %b", entry_write, busy);
  end

endmodule

// ==== source/rs_pkg.sv ====
`include "rs_params.svh"

package rs_pkg;

  // Physical register tag
  typedef logic [$clog2(`RS_NUM_PR)-1:0] pr_tag_t;

  // Reorder buffer index, wraps modulo the depth
  typedef logic [$clog2(`RS_NUM_ROB)-1:0] rob_idx_t;

  // Functional unit kind
  typedef logic [1:0] fu_kind_t;

  // Operation code handed to the unit
  typedef logic [5:0] op_code_t;

  // Station entry number
  typedef logic [$clog2(`RS_NUM_ENTRIES)-1:0] entry_idx_t;

  // Entry state machine
  typedef enum logic {
    ENTRY_IDLE,     // Free for dispatch
    ENTRY_WAITING   // Holds an instruction
  } entry_state_t;

endpackage

// ==== source/rs_params.svh ====
`ifndef RS_PARAMS_SVH
`define RS_PARAMS_SVH

// Station size, one entry per functional unit
`define RS_NUM_ENTRIES 6

// Physical register file and reorder buffer depth
`define RS_NUM_PR 64
`define RS_NUM_ROB 32

// Tag that never names a producer
`define RS_ZERO_PR 0

// Unit kind codes
`define FU_ALU    2'd0
`define FU_MULT   2'd1
`define FU_MEM    2'd2
`define FU_BRANCH 2'd3

// Unit kind per entry, entry 0 in the low bits
`define RS_FU_LIST {`FU_ALU, `FU_BRANCH, `FU_MEM, `FU_MULT, `FU_ALU, `FU_ALU}

`endif
